// File: bench/lidar_scan_tb.sv
module lidar_scan_tb
	import lidar_cfg_pkg::*;
	import lidar_scan_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_TEETH     = 16;
	localparam int RESO_LOG2   = 2;
	localparam int PWM_PERIOD  = 100;
	localparam int LASER_W     = 3;
	localparam int LOCK_REVS   = 2;
	localparam int QUEUE_DEPTH = 4;

	localparam int STEPS_REV = N_TEETH << RESO_LOG2;
	localparam int TOOTH_LEN = 200;
	localparam int GAP_LEN   = 400;
	localparam int SLOT_LOW  = 20;	// cycles the opto input stays low per slot
	localparam int STEP_LEN  = TOOTH_LEN >> RESO_LOG2;
	localparam int REV_LEN   = (N_TEETH - 1) * TOOTH_LEN + GAP_LEN;
	localparam int PWM_DUTY  = 37;
	localparam int ANGLE_OFS = 5;
	localparam int ECHO_MAX  = 35;	// below the 40 cycle window

	// mode bits: 0 motor_en, 1 laser_en, 2 free_run
	localparam logic [15:0] MODE_MOTOR = 16'h0001;
	localparam logic [15:0] MODE_FIRE  = 16'h0007;

	logic               w_pll_50m;
	logic               i_reset;
	logic               i_opto_switch;
	logic               i_echo;
	logic               i_cfg_wr;
	logic [3:0]         i_cfg_addr;
	logic [15:0]        i_cfg_data;
	logic               i_point_ready;
	logic               o_motor_pwm;
	logic               o_laser_str;
	logic               o_disable_tdc;
	logic               o_zero_sign;
	logic               o_motor_state;
	logic               o_point_valid;
	logic [ANGLE_W-1:0] o_point_angle;
	logic [DIST_W-1:0]  o_point_dist;
	logic [DROP_W-1:0]  o_drop_cnt;

	int                 value_errs;
	int                 timeout_errs;
	integer             seed;
	bit                 disc_on;
	bit                 miss_req;
	bit                 echo_on;
	bit                 disc_miss;
	bit                 echo_laser_prev;
	bit                 mon_laser_prev;
	bit                 held;
	int                 echo_k;
	int                 mon_cycle;
	int                 slot;
	int                 win_run;
	logic [ANGLE_W-1:0] held_angle;
	logic [DIST_W-1:0]  held_dist;
	int                 exp_k_q[$];
	logic [ANGLE_W-1:0] got_angle_q[$];
	logic [DIST_W-1:0]  got_dist_q[$];
	int                 laser_rise_q[$];
	int                 win_len_q[$];

	lidar_scan_top #(
		.N_TEETH       (N_TEETH),
		.RESO_LOG2     (RESO_LOG2),
		.PWM_PERIOD    (PWM_PERIOD),
		.LASER_W       (LASER_W),
		.LOCK_REVS     (LOCK_REVS),
		.QUEUE_DEPTH   (QUEUE_DEPTH)
	) lidar_scan_top_inst (
		.w_pll_50m     (w_pll_50m),
		.i_reset       (i_reset),
		.i_opto_switch (i_opto_switch),
		.i_echo        (i_echo),
		.i_cfg_wr      (i_cfg_wr),
		.i_cfg_addr    (i_cfg_addr),
		.i_cfg_data    (i_cfg_data),
		.o_motor_pwm   (o_motor_pwm),
		.o_laser_str   (o_laser_str),
		.o_disable_tdc (o_disable_tdc),
		.o_zero_sign   (o_zero_sign),
		.o_motor_state (o_motor_state),
		.i_point_ready (i_point_ready),
		.o_point_valid (o_point_valid),
		.o_point_angle (o_point_angle),
		.o_point_dist  (o_point_dist),
		.o_drop_cnt    (o_drop_cnt)
	);

	initial begin
		w_pll_50m = 1'b0;
		forever #10 w_pll_50m = ~w_pll_50m;
	end

	task automatic tick();
		@(posedge w_pll_50m);
		#2;
	endtask

	task automatic report_error(input string msg);
		value_errs++;
		$display("[ERROR] %0t: %s", $time, msg);
	endtask

	task automatic note_timeout(input string what);
		timeout_errs++;
		$display("Timed out at %0t while waiting for %s", $time, what);
	endtask

	task automatic cfg_write(input logic [3:0] addr, input logic [15:0] data);
		i_cfg_wr   = 1'b1;
		i_cfg_addr = addr;
		i_cfg_data = data;
		tick();
		i_cfg_wr   = 1'b0;
	endtask

	task automatic disc_slot(input int len);
		i_opto_switch = 1'b0;	// fall starts the slot
		repeat (SLOT_LOW) tick();
		i_opto_switch = 1'b1;
		repeat (len - SLOT_LOW) tick();
	endtask

	// one revolution per pass, the long last slot is the zero gap
	initial begin
		forever begin
			if (!disc_on) begin
				tick();
			end else begin
				disc_miss = miss_req;
				miss_req  = 1'b0;
				for (slot = 0; slot < N_TEETH; slot++) begin
					if (!(disc_miss && slot == N_TEETH - 2))
						disc_slot((slot == N_TEETH - 1) ? GAP_LEN : TOOTH_LEN);
				end
			end
		end
	end

	// echo k cycles after the strobe edge, or none
	initial begin
		forever begin
			tick();
			if (o_laser_str && !echo_laser_prev) begin
				if (echo_on) begin
					echo_k = 2 + ($unsigned($random(seed)) % (ECHO_MAX - 1));
					exp_k_q.push_back(echo_k);
					repeat (echo_k - 1) tick();
					i_echo = 1'b1;
					repeat (2) tick();
					i_echo = 1'b0;
				end else begin
					exp_k_q.push_back(DIST_NO_ECHO);
				end
			end
			echo_laser_prev = o_laser_str;
		end
	end

	// point stream, strobe edges and stop windows, sampled mid cycle
	initial begin
		forever begin
			@(negedge w_pll_50m);
			mon_cycle++;
			if (held && (!o_point_valid || o_point_angle != held_angle ||
					o_point_dist != held_dist))
				report_error("point valid or data changed before its transfer");
			if (o_point_valid && i_point_ready) begin
				got_angle_q.push_back(o_point_angle);
				got_dist_q.push_back(o_point_dist);
			end
			held       = o_point_valid && !i_point_ready;
			held_angle = o_point_angle;
			held_dist  = o_point_dist;
			if (o_laser_str && !mon_laser_prev)
				laser_rise_q.push_back(mon_cycle);
			mon_laser_prev = o_laser_str;
			if (!o_disable_tdc) begin
				win_run++;
			end else if (win_run != 0) begin
				win_len_q.push_back(win_run);
				win_run = 0;
			end
		end
	end

	task automatic wait_zero_mark(input int limit);
		int n;
		n = 0;
		tick();
		while (!o_zero_sign && n < limit) begin
			tick();
			n++;
		end
		if (!o_zero_sign)
			note_timeout("zero mark");
	endtask

	task automatic wait_unlock(input int limit);
		int n;
		n = 0;
		while (o_motor_state && n < limit) begin
			tick();
			n++;
		end
		if (o_motor_state)
			note_timeout("motor lock to clear");
	endtask

	task automatic wait_laser_shots(input int shots, input int limit);
		int n;
		n = 0;
		while (laser_rise_q.size() < shots && n < limit) begin
			tick();
			n++;
		end
		if (laser_rise_q.size() < shots)
			note_timeout("laser strobes");
	endtask

	task automatic wait_points(input int pts, input int limit);
		int n;
		n = 0;
		while (got_angle_q.size() < pts && n < limit) begin
			tick();
			n++;
		end
		if (got_angle_q.size() < pts)
			note_timeout("points on the output stream");
	endtask

	task automatic wait_drop_count(input int value, input int limit);
		int n;
		n = 0;
		while (o_drop_cnt != value && n < limit) begin
			tick();
			n++;
		end
		if (o_drop_cnt != value)
			note_timeout("drop counter");
	endtask

	task automatic check_idle(input string when);
		if (o_motor_pwm || o_laser_str || o_point_valid || o_zero_sign || o_motor_state)
			report_error($sformatf("control output high %s", when));
		if (o_disable_tdc !== 1'b1)
			report_error($sformatf("stop window not closed %s", when));
		if (o_drop_cnt !== '0)
			report_error($sformatf("drop count %0d %s", o_drop_cnt, when));
	endtask

	// step s of a revolution comes s*STEP_LEN cycles after the zero mark
	task automatic fire_burst(input int start_step, input int shots);
		exp_k_q.delete();
		got_angle_q.delete();
		got_dist_q.delete();
		laser_rise_q.delete();
		win_len_q.delete();
		win_run = 0;
		wait_zero_mark(2 * REV_LEN);
		repeat (start_step * STEP_LEN - 20) tick();
		cfg_write(CFG_ADDR_MODE, MODE_FIRE);
		wait_laser_shots(shots, (shots + 8) * STEP_LEN);
		cfg_write(CFG_ADDR_MODE, MODE_MOTOR);
	endtask

	task automatic check_points(input int start_step, input int stride, input int pts);
		int i;
		int exp_angle;
		if (got_angle_q.size() != pts || exp_k_q.size() < pts)
			report_error($sformatf("%0d points out, %0d shots, %0d expected",
				got_angle_q.size(), exp_k_q.size(), pts));
		for (i = 0; i < pts && i < got_angle_q.size() && i < exp_k_q.size(); i++) begin
			exp_angle = (start_step + i * stride + ANGLE_OFS) % STEPS_REV;
			if (got_angle_q[i] != ANGLE_W'(exp_angle))
				report_error($sformatf("point %0d angle %0d, expected %0d",
					i, got_angle_q[i], exp_angle));
			if (got_dist_q[i] != DIST_W'(exp_k_q[i]))
				report_error($sformatf("point %0d distance %0d, expected %0d",
					i, got_dist_q[i], exp_k_q[i]));
		end
	endtask

	// one stop window per strobe, each open for the programmed cycles
	task automatic check_windows(input int len);
		int i;
		if (win_len_q.size() != laser_rise_q.size())
			report_error($sformatf("%0d stop windows for %0d strobes",
				win_len_q.size(), laser_rise_q.size()));
		for (i = 0; i < win_len_q.size(); i++) begin
			if (win_len_q[i] != len)
				report_error($sformatf("stop window %0d open %0d cycles, expected %0d",
					i, win_len_q[i], len));
		end
	endtask

	task automatic test_reset();
		int i;
		for (i = 0; i < 8; i++) begin
			tick();
			check_idle("during reset");
		end
		i_reset = 1'b0;
		tick();
		check_idle("after reset");
	endtask

	task automatic test_pwm();
		int w;
		int high;
		cfg_write(CFG_ADDR_PWM_DUTY, PWM_DUTY);
		cfg_write(CFG_ADDR_MODE, MODE_MOTOR);
		repeat (5) tick();
		for (w = 0; w < 3; w++) begin
			high = 0;
			repeat (PWM_PERIOD) begin
				tick();
				if (o_motor_pwm)
					high++;
			end
			if (high != PWM_DUTY)
				report_error($sformatf("pwm high %0d cycles, expected %0d", high, PWM_DUTY));
		end
		cfg_write(CFG_ADDR_MODE, 16'h0000);
		tick();
		high = 0;
		repeat (2 * PWM_PERIOD) begin
			tick();
			if (o_motor_pwm)
				high++;
		end
		if (high != 0)
			report_error($sformatf("pwm high %0d cycles with motor off", high));
		cfg_write(CFG_ADDR_MODE, MODE_MOTOR);
	endtask

	task automatic test_zero_lock();
		int n;
		int z_count;
		int last_z;
		disc_on = 1'b1;
		n       = 0;
		z_count = 0;
		last_z  = -1;
		while (!o_motor_state && n < 6 * REV_LEN) begin
			tick();
			n++;
			if (o_zero_sign) begin
				if (last_z >= 0 && n - last_z != REV_LEN)
					report_error($sformatf("zero marks %0d cycles apart", n - last_z));
				last_z = n;
				z_count++;
			end
		end
		if (!o_motor_state)
			note_timeout("motor lock");
		else if (z_count - 1 != LOCK_REVS)	// first mark only opens the count
			report_error($sformatf("lock after %0d marked revolutions", z_count - 1));
		miss_req = 1'b1;
		wait_unlock(3 * REV_LEN);
	endtask

	task automatic test_points();
		echo_on = 1'b1;
		cfg_write(CFG_ADDR_ANGLE_OFS, ANGLE_OFS);
		cfg_write(CFG_ADDR_STOP_WIN, 40);
		fire_burst(STEPS_REV - 4, 8);	// crosses the wrap
		wait_points(8, 20 * STEP_LEN);
		repeat (3 * STEP_LEN) tick();
		check_points(STEPS_REV - 4, 1, 8);
		check_windows(40);
	endtask

	task automatic test_no_echo();
		int i;
		echo_on = 1'b0;
		cfg_write(CFG_ADDR_STOP_WIN, 80);	// spans one extra step
		fire_burst(1, 4);
		wait_points(4, 20 * STEP_LEN);
		repeat (3 * STEP_LEN) tick();
		for (i = 1; i < laser_rise_q.size(); i++) begin
			if (laser_rise_q[i] - laser_rise_q[i - 1] != 2 * STEP_LEN)
				report_error($sformatf("strobes %0d cycles apart, expected %0d",
					laser_rise_q[i] - laser_rise_q[i - 1], 2 * STEP_LEN));
		end
		check_points(1, 2, 4);
		check_windows(80);
	endtask

	task automatic test_back_pressure();
		echo_on = 1'b1;
		cfg_write(CFG_ADDR_STOP_WIN, 40);
		i_point_ready = 1'b0;
		fire_burst(1, 6);
		wait_drop_count(2, 10 * STEP_LEN);
		repeat (STEP_LEN) tick();
		if (o_drop_cnt != 2 || !o_point_valid || got_angle_q.size() != 0)
			report_error($sformatf("stalled queue: drop %0d valid %0b out %0d",
				o_drop_cnt, o_point_valid, got_angle_q.size()));
		i_point_ready = 1'b1;
		wait_points(QUEUE_DEPTH, 20);
		repeat (10) tick();
		check_points(1, 1, QUEUE_DEPTH);
		check_windows(40);
		if (o_point_valid || o_drop_cnt != 2)
			report_error($sformatf("after drain: valid %0b drop %0d", o_point_valid, o_drop_cnt));
	endtask

	initial begin
		value_errs    = 0;
		timeout_errs  = 0;
		seed          = 21454;
		i_reset       = 1'b1;
		i_opto_switch = 1'b1;
		i_echo        = 1'b0;
		i_cfg_wr      = 1'b0;
		i_cfg_addr    = '0;
		i_cfg_data    = '0;
		i_point_ready = 1'b1;
		test_reset();
		test_pwm();
		test_zero_lock();
		test_points();
		test_no_echo();
		test_back_pressure();
		$display("Errors: %0d wrong values, %0d timeouts", value_errs, timeout_errs);
		if (value_errs == 0 && timeout_errs == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: build.f
hdl/lidar_cfg_pkg.sv
hdl/lidar_scan_pkg.sv
hdl/config_regs.sv
hdl/rotate_control.sv
hdl/laser_control.sv
hdl/point_packer.sv
hdl/lidar_scan_top.sv
bench/lidar_scan_tb.sv

// File: hdl/config_regs.sv
module config_regs
	import lidar_cfg_pkg::*;
	import lidar_scan_pkg::*;
(
	input  logic                  w_pll_50m,
	input  logic                  i_reset,

	input  logic                  i_cfg_wr,
	input  logic [CFG_ADDR_W-1:0] i_cfg_addr,
	input  logic [CFG_DATA_W-1:0] i_cfg_data,

	output cfg_mode_u             o_mode,
	output logic [15:0]           o_pwm_duty,
	output logic [15:0]           o_stop_win,
	output logic [ANGLE_W-1:0]    o_angle_ofs
);

	always_ff @(posedge w_pll_50m) begin
		if (i_reset) begin
			o_mode      <= CFG_MODE_RESET;
			o_pwm_duty  <= '0;
			o_stop_win  <= '0;
			o_angle_ofs <= '0;
		end else if (i_cfg_wr) begin
			case (i_cfg_addr)
				CFG_ADDR_MODE:      o_mode.raw  <= i_cfg_data;
				CFG_ADDR_PWM_DUTY:  o_pwm_duty  <= i_cfg_data;
				CFG_ADDR_STOP_WIN:  o_stop_win  <= i_cfg_data;
				CFG_ADDR_ANGLE_OFS: o_angle_ofs <= i_cfg_data[ANGLE_W-1:0];
				default: ;	// unmapped, dropped
			endcase
		end
	end

	// host only addresses the four mapped registers
	a_cfg_addr: assert property (@(posedge w_pll_50m) disable iff (i_reset)
		i_cfg_wr |-> (i_cfg_addr <= CFG_ADDR_ANGLE_OFS));

endmodule

// File: hdl/laser_control.sv
module laser_control
	import lidar_cfg_pkg::*;
#(
	parameter int LASER_W = 3
)(
	input  logic        w_pll_50m,
	input  logic        i_reset,

	input  logic        i_angle_sync,
	input  logic        i_motor_state,
	input  cfg_mode_u   i_mode,
	input  logic [15:0] i_stop_win,

	output logic        o_laser_str,
	output logic        o_disable_tdc,
	output logic        o_fire
);

	localparam int STR_W = $clog2(LASER_W + 1);

	logic             w_allow;
	logic             w_start;
	logic [STR_W-1:0] r_str_cnt;
	logic [15:0]      r_win_cnt;

	assign w_allow = i_mode.fields.laser_en && (i_motor_state || i_mode.fields.free_run);
	assign w_start = i_angle_sync && w_allow && o_disable_tdc && !o_laser_str &&
		(i_stop_win != '0);

	always_ff @(posedge w_pll_50m) begin
		if (i_reset) begin
			o_fire        <= 1'b0;
			o_laser_str   <= 1'b0;
			r_str_cnt     <= '0;
			o_disable_tdc <= 1'b1;
			r_win_cnt     <= '0;
		end else begin
			o_fire <= w_start;
			if (w_start) begin
				o_laser_str <= 1'b1;
				r_str_cnt   <= STR_W'(LASER_W - 1);
			end else if (r_str_cnt != '0) begin
				r_str_cnt <= r_str_cnt - 1'b1;
			end else begin
				o_laser_str <= 1'b0;
			end
			if (w_start) begin
				o_disable_tdc <= 1'b0;	// stop window opens with the strobe
				r_win_cnt     <= i_stop_win - 1'b1;
			end else if (r_win_cnt != '0) begin
				r_win_cnt <= r_win_cnt - 1'b1;
			end else begin
				o_disable_tdc <= 1'b1;
			end
		end
	end

	a_fire_closed: assert property (@(posedge w_pll_50m) disable iff (i_reset)
		o_fire |-> $past(o_disable_tdc));

endmodule

// File: hdl/lidar_cfg_pkg.sv
package lidar_cfg_pkg;

	localparam int CFG_ADDR_W = 4;
	localparam int CFG_DATA_W = 16;

	localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_MODE      = 4'd0;
	localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_PWM_DUTY  = 4'd1;
	localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_STOP_WIN  = 4'd2;
	localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_ANGLE_OFS = 4'd3;

	// mode word, written whole by the host and read bit by bit by the control blocks
	typedef union packed {
		logic [CFG_DATA_W-1:0] raw;
		struct packed {
			logic [12:0] reserved;
			logic        free_run;	// fire before motor lock
			logic        laser_en;
			logic        motor_en;
		} fields;
	} cfg_mode_u;

	localparam cfg_mode_u CFG_MODE_RESET = 16'h0000;

endpackage

// File: hdl/lidar_scan_pkg.sv
package lidar_scan_pkg;

	localparam int ANGLE_W  = 12;	// angle index
	localparam int DIST_W   = 16;	// distance in clock cycles
	localparam int PERIOD_W = 20;	// tooth period counter
	localparam int DROP_W   = 8;	// dropped point counter

	localparam logic [DIST_W-1:0] DIST_NO_ECHO = {DIST_W{1'b1}};

endpackage

// File: hdl/lidar_scan_top.sv
module lidar_scan_top
	import lidar_cfg_pkg::*;
	import lidar_scan_pkg::*;
#(
	parameter int N_TEETH     = 16,
	parameter int RESO_LOG2   = 2,
	parameter int PWM_PERIOD  = 100,
	parameter int LASER_W     = 3,
	parameter int LOCK_REVS   = 2,
	parameter int QUEUE_DEPTH = 4
)(
	input  logic                  w_pll_50m,
	input  logic                  i_reset,

	input  logic                  i_opto_switch,
	input  logic                  i_echo,

	input  logic                  i_cfg_wr,
	input  logic [CFG_ADDR_W-1:0] i_cfg_addr,
	input  logic [CFG_DATA_W-1:0] i_cfg_data,

	output logic                  o_motor_pwm,
	output logic                  o_laser_str,
	output logic                  o_disable_tdc,
	output logic                  o_zero_sign,
	output logic                  o_motor_state,

	input  logic                  i_point_ready,
	output logic                  o_point_valid,
	output logic [ANGLE_W-1:0]    o_point_angle,
	output logic [DIST_W-1:0]     o_point_dist,
	output logic [DROP_W-1:0]     o_drop_cnt
);

	cfg_mode_u          w_mode;
	logic [15:0]        w_pwm_duty;
	logic [15:0]        w_stop_win;
	logic [ANGLE_W-1:0] w_angle_ofs;
	logic               w_angle_sync;
	logic [ANGLE_W-1:0] w_angle_idx;
	logic               w_fire;

	config_regs config_regs_inst (
		.w_pll_50m     (w_pll_50m),
		.i_reset       (i_reset),
		.i_cfg_wr      (i_cfg_wr),
		.i_cfg_addr    (i_cfg_addr),
		.i_cfg_data    (i_cfg_data),
		.o_mode        (w_mode),
		.o_pwm_duty    (w_pwm_duty),
		.o_stop_win    (w_stop_win),
		.o_angle_ofs   (w_angle_ofs)
	);

	rotate_control #(
		.N_TEETH       (N_TEETH),
		.RESO_LOG2     (RESO_LOG2),
		.PWM_PERIOD    (PWM_PERIOD),
		.LOCK_REVS     (LOCK_REVS)
	) rotate_control_inst (
		.w_pll_50m     (w_pll_50m),
		.i_reset       (i_reset),
		.i_opto_switch (i_opto_switch),
		.i_mode        (w_mode),
		.i_pwm_duty    (w_pwm_duty),
		.o_motor_pwm   (o_motor_pwm),
		.o_zero_sign   (o_zero_sign),
		.o_motor_state (o_motor_state),
		.o_angle_sync  (w_angle_sync),
		.o_angle_idx   (w_angle_idx)
	);

	laser_control #(
		.LASER_W       (LASER_W)
	) laser_control_inst (
		.w_pll_50m     (w_pll_50m),
		.i_reset       (i_reset),
		.i_angle_sync  (w_angle_sync),
		.i_motor_state (o_motor_state),
		.i_mode        (w_mode),
		.i_stop_win    (w_stop_win),
		.o_laser_str   (o_laser_str),
		.o_disable_tdc (o_disable_tdc),
		.o_fire        (w_fire)
	);

	point_packer #(
		.N_TEETH       (N_TEETH),
		.RESO_LOG2     (RESO_LOG2),
		.QUEUE_DEPTH   (QUEUE_DEPTH)
	) point_packer_inst (
		.w_pll_50m     (w_pll_50m),
		.i_reset       (i_reset),
		.i_fire        (w_fire),
		.i_angle_idx   (w_angle_idx),
		.i_angle_ofs   (w_angle_ofs),
		.i_disable_tdc (o_disable_tdc),
		.i_echo        (i_echo),
		.i_point_ready (i_point_ready),
		.o_point_valid (o_point_valid),
		.o_point_angle (o_point_angle),
		.o_point_dist  (o_point_dist),
		.o_drop_cnt    (o_drop_cnt)
	);

endmodule

// File: hdl/point_packer.sv
module point_packer
	import lidar_scan_pkg::*;
#(
	parameter int N_TEETH     = 16,
	parameter int RESO_LOG2   = 2,
	parameter int QUEUE_DEPTH = 4
)(
	input  logic               w_pll_50m,
	input  logic               i_reset,

	input  logic               i_fire,
	input  logic [ANGLE_W-1:0] i_angle_idx,
	input  logic [ANGLE_W-1:0] i_angle_ofs,
	input  logic               i_disable_tdc,
	input  logic               i_echo,
	input  logic               i_point_ready,

	output logic               o_point_valid,
	output logic [ANGLE_W-1:0] o_point_angle,
	output logic [DIST_W-1:0]  o_point_dist,
	output logic [DROP_W-1:0]  o_drop_cnt
);

	localparam int STEPS_REV = N_TEETH << RESO_LOG2;
	localparam int PTR_W     = $clog2(QUEUE_DEPTH);
	localparam int CNT_W     = $clog2(QUEUE_DEPTH + 1);

	logic               r_busy;
	logic [DIST_W-1:0]  r_dist_cnt;
	logic [DIST_W-1:0]  w_dist_k;
	logic               w_echo_hit;
	logic               w_no_echo;
	logic [ANGLE_W:0]   w_angle_sum;
	logic [ANGLE_W-1:0] w_angle_wrap;
	logic [ANGLE_W-1:0] r_angle;
	logic               r_done;
	logic [ANGLE_W-1:0] r_pt_angle;
	logic [DIST_W-1:0]  r_pt_dist;
	logic [ANGLE_W-1:0] r_q_angle [QUEUE_DEPTH];
	logic [DIST_W-1:0]  r_q_dist [QUEUE_DEPTH];
	logic [PTR_W-1:0]   r_wr_ptr;
	logic [PTR_W-1:0]   r_rd_ptr;
	logic [CNT_W-1:0]   r_count;
	logic               w_full;
	logic               w_push;
	logic               w_pop;

	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	// offset is below one revolution, so one subtract wraps it
	assign w_angle_sum  = {1'b0, i_angle_idx} + {1'b0, i_angle_ofs};
	assign w_angle_wrap = (w_angle_sum >= STEPS_REV) ? ANGLE_W'(w_angle_sum - STEPS_REV) :
		w_angle_sum[ANGLE_W-1:0];

	assign w_dist_k   = i_fire ? DIST_W'(1) : r_dist_cnt + 1'b1;	// k of this edge
	assign w_echo_hit = (i_fire || r_busy) && !i_disable_tdc && i_echo;
	assign w_no_echo  = r_busy && !i_fire && i_disable_tdc;

	always_ff @(posedge w_pll_50m) begin
		if (i_reset) begin
			r_busy     <= 1'b0;
			r_dist_cnt <= '0;
			r_done     <= 1'b0;
		end else begin
			r_done <= w_echo_hit || w_no_echo;
			if (w_echo_hit || w_no_echo)
				r_busy <= 1'b0;
			else if (i_fire)
				r_busy <= 1'b1;
			if (i_fire || r_busy)
				r_dist_cnt <= w_dist_k;
		end
	end

	always_ff @(posedge w_pll_50m) begin
		if (i_fire)
			r_angle <= w_angle_wrap;
		if (w_echo_hit || w_no_echo) begin
			r_pt_angle <= i_fire ? w_angle_wrap : r_angle;
			r_pt_dist  <= w_echo_hit ? w_dist_k : DIST_NO_ECHO;
		end
	end

	assign w_full = (r_count == CNT_W'(QUEUE_DEPTH));
	assign w_push = r_done && !w_full;
	assign w_pop  = o_point_valid && i_point_ready;

	always_ff @(posedge w_pll_50m) begin
		if (i_reset) begin
			r_wr_ptr   <= '0;
			r_rd_ptr   <= '0;
			r_count    <= '0;
			o_drop_cnt <= '0;
		end else begin
			if (w_push)
				r_wr_ptr <= ptr_next(r_wr_ptr);
			if (w_pop)
				r_rd_ptr <= ptr_next(r_rd_ptr);
			case ({w_push, w_pop})
				2'b10:   r_count <= r_count + 1'b1;
				2'b01:   r_count <= r_count - 1'b1;
				default: ;
			endcase
			if (r_done && w_full && (o_drop_cnt != '1))
				o_drop_cnt <= o_drop_cnt + 1'b1;	// saturating
		end
	end

	always_ff @(posedge w_pll_50m) begin
		if (w_push) begin
			r_q_angle[r_wr_ptr] <= r_pt_angle;
			r_q_dist[r_wr_ptr]  <= r_pt_dist;
		end
	end

	assign o_point_valid = (r_count != '0);
	assign o_point_angle = r_q_angle[r_rd_ptr];
	assign o_point_dist  = r_q_dist[r_rd_ptr];

	a_occupancy: assert property (@(posedge w_pll_50m) disable iff (i_reset)
		r_count <= CNT_W'(QUEUE_DEPTH));

	a_hold: assert property (@(posedge w_pll_50m) disable iff (i_reset)
		o_point_valid && !i_point_ready |=>
			o_point_valid && $stable(o_point_angle) && $stable(o_point_dist));

endmodule

// File: hdl/rotate_control.sv
module rotate_control
	import lidar_cfg_pkg::*;
	import lidar_scan_pkg::*;
#(
	parameter int N_TEETH    = 16,
	parameter int RESO_LOG2  = 2,
	parameter int PWM_PERIOD = 100,
	parameter int LOCK_REVS  = 2
)(
	input  logic               w_pll_50m,
	input  logic               i_reset,

	input  logic               i_opto_switch,
	input  cfg_mode_u          i_mode,
	input  logic [15:0]        i_pwm_duty,

	output logic               o_motor_pwm,
	output logic               o_zero_sign,
	output logic               o_motor_state,
	output logic               o_angle_sync,
	output logic [ANGLE_W-1:0] o_angle_idx
);

	localparam int STEPS   = 1 << RESO_LOG2;
	localparam int TOOTH_W = ANGLE_W - RESO_LOG2;
	localparam int FALL_W  = $clog2(N_TEETH + 1);
	localparam int CLEAN_W = $clog2(LOCK_REVS + 1);
	localparam int PWM_W   = $clog2(PWM_PERIOD);

	logic [2:0]          r_opto_sync;
	logic                w_opto_fall;
	logic [PERIOD_W-1:0] r_period_cnt;
	logic [PERIOD_W-1:0] r_last_period;
	logic [PERIOD_W:0]   w_gap_limit;
	logic                w_zero_gap;
	logic [PERIOD_W-1:0] w_period_next;
	logic [PERIOD_W-1:0] w_step_len;
	logic [TOOTH_W-1:0]  r_tooth;
	logic [TOOTH_W-1:0]  w_tooth_next;
	logic [FALL_W-1:0]   r_rev_falls;
	logic [CLEAN_W-1:0]  r_clean_revs;
	logic [PERIOD_W-1:0] r_step_timer;
	logic [RESO_LOG2:0]  r_step_num;
	logic                w_step_fire;
	logic [PWM_W-1:0]    r_pwm_cnt;

	assign w_opto_fall   = r_opto_sync[2] & ~r_opto_sync[1];
	assign w_gap_limit   = {1'b0, r_last_period} + {2'b00, r_last_period[PERIOD_W-1:1]};
	assign w_zero_gap    = (r_last_period != '0) && ({1'b0, r_period_cnt} > w_gap_limit);
	assign w_period_next = w_zero_gap ? r_last_period : r_period_cnt;	// gap keeps tooth timing
	assign w_step_len    = w_period_next >> RESO_LOG2;
	assign w_tooth_next  = w_zero_gap ? '0 : r_tooth + 1'b1;
	assign w_step_fire   = !w_opto_fall && (r_step_num != '0) && (r_step_num < STEPS) &&
		(r_step_timer == PERIOD_W'(1));

	always_ff @(posedge w_pll_50m) begin
		if (i_reset) begin
			r_opto_sync   <= '0;
			r_period_cnt  <= '0;
			r_last_period <= '0;
		end else begin
			r_opto_sync <= {r_opto_sync[1:0], i_opto_switch};
			if (w_opto_fall) begin
				r_period_cnt  <= PERIOD_W'(1);
				r_last_period <= w_period_next;
			end else if (r_period_cnt != '1) begin
				r_period_cnt <= r_period_cnt + 1'b1;	// saturates when stalled
			end
		end
	end

	// zero mark, tooth count and lock over whole revolutions
	always_ff @(posedge w_pll_50m) begin
		if (i_reset) begin
			o_zero_sign   <= 1'b0;
			r_tooth       <= '0;
			r_rev_falls   <= '0;
			r_clean_revs  <= '0;
			o_motor_state <= 1'b0;
		end else begin
			o_zero_sign <= w_opto_fall && w_zero_gap;
			if (w_opto_fall) begin
				r_tooth <= w_tooth_next;
				if (w_zero_gap) begin
					r_rev_falls <= '0;
					if (r_rev_falls == FALL_W'(N_TEETH - 1)) begin
						if (r_clean_revs != CLEAN_W'(LOCK_REVS))
							r_clean_revs <= r_clean_revs + 1'b1;
						if (r_clean_revs >= CLEAN_W'(LOCK_REVS - 1))
							o_motor_state <= 1'b1;
					end else begin
						r_clean_revs  <= '0;
						o_motor_state <= 1'b0;
					end
				end else if (r_rev_falls >= FALL_W'(N_TEETH - 1)) begin
					r_rev_falls   <= FALL_W'(N_TEETH);	// too many slots, hold as bad
					r_clean_revs  <= '0;
					o_motor_state <= 1'b0;
				end else begin
					r_rev_falls <= r_rev_falls + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge w_pll_50m) begin
		if (i_reset) begin
			o_angle_sync <= 1'b0;
			o_angle_idx  <= '0;
			r_step_num   <= '0;
			r_step_timer <= '0;
		end else begin
			o_angle_sync <= w_opto_fall || w_step_fire;
			if (w_opto_fall) begin
				o_angle_idx  <= {w_tooth_next, {RESO_LOG2{1'b0}}};
				r_step_num   <= {{RESO_LOG2{1'b0}}, 1'b1};
				r_step_timer <= w_step_len;
			end else if (w_step_fire) begin
				o_angle_idx  <= {r_tooth, r_step_num[RESO_LOG2-1:0]};
				r_step_num   <= r_step_num + 1'b1;
				r_step_timer <= r_last_period >> RESO_LOG2;
			end else if (r_step_timer != '0) begin
				r_step_timer <= r_step_timer - 1'b1;
			end
		end
	end

	always_ff @(posedge w_pll_50m) begin
		if (i_reset || !i_mode.fields.motor_en) begin
			r_pwm_cnt   <= '0;
			o_motor_pwm <= 1'b0;
		end else begin
			r_pwm_cnt   <= (r_pwm_cnt == PWM_W'(PWM_PERIOD - 1)) ? '0 : r_pwm_cnt + 1'b1;
			o_motor_pwm <= 16'(r_pwm_cnt) < i_pwm_duty;
		end
	end

	// step field only returns to zero at a new tooth
	a_step_range: assert property (@(posedge w_pll_50m) disable iff (i_reset)
		o_angle_sync |-> $past(w_opto_fall) || (o_angle_idx[RESO_LOG2-1:0] != '0));

	a_zero_once: assert property (@(posedge w_pll_50m) disable iff (i_reset)
		o_zero_sign |=> (!o_zero_sign until w_opto_fall));

endmodule
